//--- sources.f
tcp_rx_pkg.sv
flowid_manager.sv
flow_cam.sv
tcp_rx_ctrl.sv
tcp_rx_new_flow_ctrl.sv
tcp_rx_datap.sv
tcp_rx.sv
tb_tcp_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tcp_rx -f sources.f -o sim_tcp_rx

./obj_dir/sim_tcp_rx | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi

//--- tb_tcp_rx.sv
`timescale 1ns/1ps

module tb_tcp_rx;
    import tcp_rx_pkg::*;

    localparam int MAX_FLOW_CNT = 8;
    localparam int NUM_HDRS     = 400;
    localparam int POOL_SIZE    = 12;
    localparam int CLK_PERIOD   = 8;
    localparam int MAX_PAYLOAD  = 1460;
    localparam int SEED         = 32'hc48ffd00;

    logic           clk;
    logic           rst_n_i;
    logic           recv_hdr_val_i;
    ip_addr_t       recv_src_ip_i;
    ip_addr_t       recv_dst_ip_i;
    port_t          recv_src_port_i;
    port_t          recv_dst_port_i;
    seq_num_t       recv_seq_num_i;
    tcp_flags_t     recv_flags_i;
    payload_len_t   recv_payload_len_i;
    logic           recv_hdr_rdy_o;
    logic           tcp_rx_dst_hdr_val_o;
    flowid_t        tcp_rx_dst_flowid_o;
    logic           tcp_rx_dst_pkt_accept_o;
    logic           dst_tcp_rx_hdr_rdy_i;
    logic           app_new_flow_notif_val_o;
    flowid_t        app_new_flow_flowid_o;
    four_tuple_t    app_new_flow_entry_o;
    logic           app_new_flow_notif_rdy_i;

    tcp_rx #(
         .MAX_FLOW_CNT  (MAX_FLOW_CNT)
    ) tcp_rx_i (
         .clk                       (clk                        )
        ,.rst_n_i                   (rst_n_i                    )
        ,.recv_hdr_val_i            (recv_hdr_val_i             )
        ,.recv_src_ip_i             (recv_src_ip_i              )
        ,.recv_dst_ip_i             (recv_dst_ip_i              )
        ,.recv_src_port_i           (recv_src_port_i            )
        ,.recv_dst_port_i           (recv_dst_port_i            )
        ,.recv_seq_num_i            (recv_seq_num_i             )
        ,.recv_flags_i              (recv_flags_i               )
        ,.recv_payload_len_i        (recv_payload_len_i         )
        ,.recv_hdr_rdy_o            (recv_hdr_rdy_o             )
        ,.tcp_rx_dst_hdr_val_o      (tcp_rx_dst_hdr_val_o       )
        ,.tcp_rx_dst_flowid_o       (tcp_rx_dst_flowid_o        )
        ,.tcp_rx_dst_pkt_accept_o   (tcp_rx_dst_pkt_accept_o    )
        ,.dst_tcp_rx_hdr_rdy_i      (dst_tcp_rx_hdr_rdy_i       )
        ,.app_new_flow_notif_val_o  (app_new_flow_notif_val_o   )
        ,.app_new_flow_flowid_o     (app_new_flow_flowid_o      )
        ,.app_new_flow_entry_o      (app_new_flow_entry_o       )
        ,.app_new_flow_notif_rdy_i  (app_new_flow_notif_rdy_i   )
    );

    // Source port doubles as a unique tag in the tuple pool
    ip_addr_t       pool_src_ip   [POOL_SIZE];
    ip_addr_t       pool_dst_ip   [POOL_SIZE];
    port_t          pool_src_port [POOL_SIZE];
    port_t          pool_dst_port [POOL_SIZE];

    // Reference model state
    int             flow_of_tuple [POOL_SIZE];
    logic           id_used       [MAX_FLOW_CNT];
    seq_num_t       exp_seq       [MAX_FLOW_CNT];

    flowid_t        exp_out_flowid_q [$];
    logic           exp_out_accept_q [$];
    flowid_t        exp_nf_flowid_q  [$];
    four_tuple_t    exp_nf_tuple_q   [$];

    int             mismatch_errs;
    int             protocol_errs;
    int             missing_errs;
    int             sent;
    int             drain_cnt;

    int             cur_tuple;
    logic           cur_syn;
    seq_num_t       cur_seq;
    payload_len_t   cur_len;

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic four_tuple_t pool_tuple(input int t);
        return {pool_src_ip[t], pool_dst_ip[t], pool_src_port[t], pool_dst_port[t]};
    endfunction

    function automatic int lowest_free_id();
        for (int i = 0; i < MAX_FLOW_CNT; i++) begin
            if (!id_used[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_dst_hdr(input flowid_t exp_id, input logic exp_acc,
                                 input flowid_t got_id, input logic got_acc);
        if (exp_id !== got_id || exp_acc !== got_acc) begin
            $display("ERR %0t: output header flowid %0d accept %0b, expected flowid %0d accept %0b",
                     $time, got_id, got_acc, exp_id, exp_acc);
            mismatch_errs++;
        end
    endtask

    task automatic check_new_flow(input flowid_t exp_id, input four_tuple_t exp_tuple,
                                  input flowid_t got_id, input four_tuple_t got_tuple);
        if (exp_id !== got_id || exp_tuple !== got_tuple) begin
            $display("ERR %0t: notification flowid %0d tuple %h, expected flowid %0d tuple %h",
                     $time, got_id, got_tuple, exp_id, exp_tuple);
            mismatch_errs++;
        end
    endtask

    // Applies the receive rules to the header that just transferred
    task automatic apply_header_to_model();
        int id;
        id = flow_of_tuple[cur_tuple];
        if (cur_syn) begin
            if (id < 0) begin
                id = lowest_free_id();
                if (id >= 0) begin
                    id_used[id]              = 1'b1;
                    flow_of_tuple[cur_tuple] = id;
                    exp_seq[id]              = cur_seq + seq_num_t'(1);
                    exp_nf_flowid_q.push_back(flowid_t'(id));
                    exp_nf_tuple_q.push_back(pool_tuple(cur_tuple));
                end
            end
        end else if (id >= 0) begin
            exp_out_flowid_q.push_back(flowid_t'(id));
            if (cur_seq == exp_seq[id]) begin
                exp_out_accept_q.push_back(1'b1);
                exp_seq[id] = exp_seq[id] + seq_num_t'(cur_len);
            end else begin
                exp_out_accept_q.push_back(1'b0);
            end
        end
    endtask

    task automatic drive_new_header();
        tcp_flags_t flags;
        int         id;
        cur_tuple = int'($urandom_range(POOL_SIZE - 1));
        cur_syn   = ($urandom_range(99) < 30);
        cur_len   = payload_len_t'($urandom_range(MAX_PAYLOAD));
        id        = flow_of_tuple[cur_tuple];
        if (!cur_syn && id >= 0 && $urandom_range(99) < 60) begin
            cur_seq = exp_seq[id];
        end else begin
            cur_seq = seq_num_t'($urandom);
        end
        flags               = tcp_flags_t'($urandom);
        flags[TCP_FLAG_SYN] = cur_syn;
        recv_hdr_val_i     <= 1'b1;
        recv_src_ip_i      <= pool_src_ip[cur_tuple];
        recv_dst_ip_i      <= pool_dst_ip[cur_tuple];
        recv_src_port_i    <= pool_src_port[cur_tuple];
        recv_dst_port_i    <= pool_dst_port[cur_tuple];
        recv_seq_num_i     <= cur_seq;
        recv_flags_i       <= flags;
        recv_payload_len_i <= cur_len;
    endtask

    // Output header and notification monitors
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (tcp_rx_dst_hdr_val_o && dst_tcp_rx_hdr_rdy_i) begin
                if (exp_out_flowid_q.size() == 0) begin
                    $display("Unexpected output header at %0t", $time);
                    protocol_errs++;
                end else begin
                    check_dst_hdr(exp_out_flowid_q.pop_front(), exp_out_accept_q.pop_front(),
                                  tcp_rx_dst_flowid_o, tcp_rx_dst_pkt_accept_o);
                end
            end
            if (app_new_flow_notif_val_o && app_new_flow_notif_rdy_i) begin
                if (exp_nf_flowid_q.size() == 0) begin
                    $display("Unexpected new flow notification at %0t", $time);
                    protocol_errs++;
                end else begin
                    check_new_flow(exp_nf_flowid_q.pop_front(), exp_nf_tuple_q.pop_front(),
                                   app_new_flow_flowid_o, app_new_flow_entry_o);
                end
            end
        end
    end

    initial begin
        #(NUM_HDRS * 60 * CLK_PERIOD);
        $display("Timeout: the run did not finish in the allowed time");
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk                      = 1'b0;
        rst_n_i                  = 1'b0;
        recv_hdr_val_i           = 1'b0;
        recv_src_ip_i            = '0;
        recv_dst_ip_i            = '0;
        recv_src_port_i          = '0;
        recv_dst_port_i          = '0;
        recv_seq_num_i           = '0;
        recv_flags_i             = '0;
        recv_payload_len_i       = '0;
        dst_tcp_rx_hdr_rdy_i     = 1'b0;
        app_new_flow_notif_rdy_i = 1'b0;
        mismatch_errs            = 0;
        protocol_errs            = 0;
        missing_errs             = 0;
        sent                     = 0;

        for (int t = 0; t < POOL_SIZE; t++) begin
            pool_src_ip[t]   = ip_addr_t'($urandom);
            pool_dst_ip[t]   = ip_addr_t'($urandom);
            pool_src_port[t] = port_t'(32'h1000 + t);
            pool_dst_port[t] = port_t'($urandom);
            flow_of_tuple[t] = -1;
        end
        for (int i = 0; i < MAX_FLOW_CNT; i++) begin
            id_used[i] = 1'b0;
            exp_seq[i] = '0;
        end

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;

        while (sent < NUM_HDRS) begin
            @(posedge clk);
            dst_tcp_rx_hdr_rdy_i     <= 1'($urandom_range(1));
            app_new_flow_notif_rdy_i <= 1'($urandom_range(1));
            if (recv_hdr_val_i && recv_hdr_rdy_o) begin
                if (exp_out_flowid_q.size() != 0 || exp_nf_flowid_q.size() != 0) begin
                    $display("Header taken at %0t while an earlier result was pending", $time);
                    protocol_errs++;
                end
                apply_header_to_model();
                sent++;
                recv_hdr_val_i <= 1'b0;
            end else if (!recv_hdr_val_i && $urandom_range(1) == 1) begin
                drive_new_header();
            end
        end

        drain_cnt = 0;
        while ((exp_out_flowid_q.size() != 0 || exp_nf_flowid_q.size() != 0)
               && drain_cnt < 200) begin
            @(posedge clk);
            dst_tcp_rx_hdr_rdy_i     <= 1'($urandom_range(1));
            app_new_flow_notif_rdy_i <= 1'($urandom_range(1));
            drain_cnt++;
        end
        @(posedge clk);
        dst_tcp_rx_hdr_rdy_i     <= 1'b1;
        app_new_flow_notif_rdy_i <= 1'b1;
        repeat (20) @(posedge clk);

        if (exp_out_flowid_q.size() != 0) begin
            $display("%0d output headers never arrived", exp_out_flowid_q.size());
            missing_errs += exp_out_flowid_q.size();
        end
        if (exp_nf_flowid_q.size() != 0) begin
            $display("%0d new flow notifications never arrived", exp_nf_flowid_q.size());
            missing_errs += exp_nf_flowid_q.size();
        end

        $display("Errors: %0d mismatch, %0d protocol, %0d missing",
                 mismatch_errs, protocol_errs, missing_errs);
        if (mismatch_errs == 0 && protocol_errs == 0 && missing_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tcp_rx.sv
`timescale 1ns/1ps

module tcp_rx #(
    parameter int MAX_FLOW_CNT = 8
) (
     input  logic                       clk
    ,input  logic                       rst_n_i

    ,input  logic                       recv_hdr_val_i
    ,input  tcp_rx_pkg::ip_addr_t       recv_src_ip_i
    ,input  tcp_rx_pkg::ip_addr_t       recv_dst_ip_i
    ,input  tcp_rx_pkg::port_t          recv_src_port_i
    ,input  tcp_rx_pkg::port_t          recv_dst_port_i
    ,input  tcp_rx_pkg::seq_num_t       recv_seq_num_i
    ,input  tcp_rx_pkg::tcp_flags_t     recv_flags_i
    ,input  tcp_rx_pkg::payload_len_t   recv_payload_len_i
    ,output logic                       recv_hdr_rdy_o

    ,output logic                       tcp_rx_dst_hdr_val_o
    ,output tcp_rx_pkg::flowid_t        tcp_rx_dst_flowid_o
    ,output logic                       tcp_rx_dst_pkt_accept_o
    ,input  logic                       dst_tcp_rx_hdr_rdy_i

    ,output logic                       app_new_flow_notif_val_o
    ,output tcp_rx_pkg::flowid_t        app_new_flow_flowid_o
    ,output tcp_rx_pkg::four_tuple_t    app_new_flow_entry_o
    ,input  logic                       app_new_flow_notif_rdy_i
);
    import tcp_rx_pkg::*;

    logic           read_flow_cam_hit;
    flowid_t        read_flow_cam_flowid;
    four_tuple_t    read_flow_cam_tag;

    logic           ctrl_datap_save_input;
    logic           ctrl_datap_save_lookup;
    logic           ctrl_datap_save_state;
    logic           saved_syn;

    logic           slow_path_val;
    logic           slow_path_rdy;
    logic           slow_path_done;

    logic           flowid_req;
    logic           flowid_avail;
    flowid_t        flowid_manager_flowid;
    logic           store_flowid;

    tcp_rx_ctrl ctrl (
         .clk                       (clk                    )
        ,.rst_n_i                   (rst_n_i                )
        ,.recv_hdr_val_i            (recv_hdr_val_i         )
        ,.recv_hdr_rdy_o            (recv_hdr_rdy_o         )
        ,.read_flow_cam_hit_i       (read_flow_cam_hit      )
        ,.saved_syn_i               (saved_syn              )
        ,.tcp_rx_dst_hdr_val_o      (tcp_rx_dst_hdr_val_o   )
        ,.dst_tcp_rx_hdr_rdy_i      (dst_tcp_rx_hdr_rdy_i   )
        ,.slow_path_val_o           (slow_path_val          )
        ,.slow_path_rdy_i           (slow_path_rdy          )
        ,.slow_path_done_i          (slow_path_done         )
        ,.ctrl_datap_save_input_o   (ctrl_datap_save_input  )
        ,.ctrl_datap_save_lookup_o  (ctrl_datap_save_lookup )
        ,.ctrl_datap_save_state_o   (ctrl_datap_save_state  )
    );

    tcp_rx_new_flow_ctrl new_flow_ctrl (
         .clk                       (clk                        )
        ,.rst_n_i                   (rst_n_i                    )
        ,.slow_path_val_i           (slow_path_val              )
        ,.slow_path_rdy_o           (slow_path_rdy              )
        ,.slow_path_done_o          (slow_path_done             )
        ,.flowid_avail_i            (flowid_avail               )
        ,.flowid_req_o              (flowid_req                 )
        ,.store_flowid_o            (store_flowid               )
        ,.app_new_flow_notif_val_o  (app_new_flow_notif_val_o   )
        ,.app_new_flow_notif_rdy_i  (app_new_flow_notif_rdy_i   )
    );

    tcp_rx_datap #(
         .MAX_FLOW_CNT  (MAX_FLOW_CNT)
    ) datap (
         .clk                       (clk                    )
        ,.rst_n_i                   (rst_n_i                )
        ,.recv_src_ip_i             (recv_src_ip_i          )
        ,.recv_dst_ip_i             (recv_dst_ip_i          )
        ,.recv_src_port_i           (recv_src_port_i        )
        ,.recv_dst_port_i           (recv_dst_port_i        )
        ,.recv_seq_num_i            (recv_seq_num_i         )
        ,.recv_flags_i              (recv_flags_i           )
        ,.recv_payload_len_i        (recv_payload_len_i     )
        ,.ctrl_datap_save_input_i   (ctrl_datap_save_input  )
        ,.ctrl_datap_save_lookup_i  (ctrl_datap_save_lookup )
        ,.ctrl_datap_save_state_i   (ctrl_datap_save_state  )
        ,.store_flowid_i            (store_flowid           )
        ,.saved_syn_o               (saved_syn              )
        ,.read_flow_cam_tag_o       (read_flow_cam_tag      )
        ,.read_flow_cam_flowid_i    (read_flow_cam_flowid   )
        ,.flowid_manager_flowid_i   (flowid_manager_flowid  )
        ,.tcp_rx_dst_flowid_o       (tcp_rx_dst_flowid_o    )
        ,.tcp_rx_dst_pkt_accept_o   (tcp_rx_dst_pkt_accept_o)
        ,.app_new_flow_flowid_o     (app_new_flow_flowid_o  )
        ,.app_new_flow_entry_o      (app_new_flow_entry_o   )
    );

    flowid_manager #(
         .MAX_FLOW_CNT  (MAX_FLOW_CNT)
    ) flowid_mgr (
         .clk               (clk                    )
        ,.rst_n_i           (rst_n_i                )
        ,.flowid_req_i      (flowid_req             )
        ,.flowid_avail_o    (flowid_avail           )
        ,.flowid_o          (flowid_manager_flowid  )
    );

    // New flows are written with the tuple still held in the datapath
    flow_cam #(
         .MAX_FLOW_CNT  (MAX_FLOW_CNT)
    ) tuple_to_flowid (
         .clk       (clk                    )
        ,.rst_n_i   (rst_n_i                )
        ,.w_v_i     (store_flowid           )
        ,.w_tag_i   (read_flow_cam_tag      )
        ,.w_data_i  (flowid_manager_flowid  )
        ,.r_tag_i   (read_flow_cam_tag      )
        ,.r_data_o  (read_flow_cam_flowid   )
        ,.r_v_o     (read_flow_cam_hit      )
    );

endmodule

//--- tcp_rx_datap.sv
`timescale 1ns/1ps

module tcp_rx_datap #(
    parameter int MAX_FLOW_CNT = 8
) (
     input  logic                       clk
    ,input  logic                       rst_n_i

    ,input  tcp_rx_pkg::ip_addr_t       recv_src_ip_i
    ,input  tcp_rx_pkg::ip_addr_t       recv_dst_ip_i
    ,input  tcp_rx_pkg::port_t          recv_src_port_i
    ,input  tcp_rx_pkg::port_t          recv_dst_port_i
    ,input  tcp_rx_pkg::seq_num_t       recv_seq_num_i
    ,input  tcp_rx_pkg::tcp_flags_t     recv_flags_i
    ,input  tcp_rx_pkg::payload_len_t   recv_payload_len_i

    ,input  logic                       ctrl_datap_save_input_i
    ,input  logic                       ctrl_datap_save_lookup_i
    ,input  logic                       ctrl_datap_save_state_i
    ,input  logic                       store_flowid_i
    ,output logic                       saved_syn_o

    ,output tcp_rx_pkg::four_tuple_t    read_flow_cam_tag_o
    ,input  tcp_rx_pkg::flowid_t        read_flow_cam_flowid_i
    ,input  tcp_rx_pkg::flowid_t        flowid_manager_flowid_i

    ,output tcp_rx_pkg::flowid_t        tcp_rx_dst_flowid_o
    ,output logic                       tcp_rx_dst_pkt_accept_o
    ,output tcp_rx_pkg::flowid_t        app_new_flow_flowid_o
    ,output tcp_rx_pkg::four_tuple_t    app_new_flow_entry_o
);
    import tcp_rx_pkg::*;

    ip_addr_t       src_ip_q;
    ip_addr_t       dst_ip_q;
    port_t          src_port_q;
    port_t          dst_port_q;
    seq_num_t       seq_num_q;
    tcp_flags_t     flags_q;
    payload_len_t   payload_len_q;

    flowid_t        flowid_q;
    flowid_t        new_flowid_q;
    logic           accept_q;
    logic           seq_match;

    // Next expected sequence number of each flow
    seq_num_t       exp_seq_q [MAX_FLOW_CNT];

    always_ff @(posedge clk) begin
        if (ctrl_datap_save_input_i) begin
            src_ip_q      <= recv_src_ip_i;
            dst_ip_q      <= recv_dst_ip_i;
            src_port_q    <= recv_src_port_i;
            dst_port_q    <= recv_dst_port_i;
            seq_num_q     <= recv_seq_num_i;
            flags_q       <= recv_flags_i;
            payload_len_q <= recv_payload_len_i;
        end
        if (ctrl_datap_save_lookup_i) begin
            flowid_q <= read_flow_cam_flowid_i;
        end
        if (store_flowid_i) begin
            new_flowid_q <= flowid_manager_flowid_i;
        end
    end

    assign read_flow_cam_tag_o = {src_ip_q, dst_ip_q, src_port_q, dst_port_q};
    assign saved_syn_o         = flags_q[TCP_FLAG_SYN];

    assign seq_match = (seq_num_q == exp_seq_q[flowid_q]);

    // SYN consumes one sequence number
    always_ff @(posedge clk) begin
        if (store_flowid_i) begin
            exp_seq_q[flowid_manager_flowid_i] <= seq_num_q + seq_num_t'(1);
        end else if (ctrl_datap_save_state_i && seq_match) begin
            exp_seq_q[flowid_q] <= exp_seq_q[flowid_q] + seq_num_t'(payload_len_q);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            accept_q <= 1'b0;
        end else if (ctrl_datap_save_state_i) begin
            accept_q <= seq_match;
        end
    end

    assign tcp_rx_dst_flowid_o     = flowid_q;
    assign tcp_rx_dst_pkt_accept_o = accept_q;
    assign app_new_flow_flowid_o   = new_flowid_q;
    assign app_new_flow_entry_o    = read_flow_cam_tag_o;

endmodule

//--- tcp_rx_new_flow_ctrl.sv
`timescale 1ns/1ps

module tcp_rx_new_flow_ctrl (
     input  logic   clk
    ,input  logic   rst_n_i

    ,input  logic   slow_path_val_i
    ,output logic   slow_path_rdy_o
    ,output logic   slow_path_done_o

    ,input  logic   flowid_avail_i
    ,output logic   flowid_req_o
    ,output logic   store_flowid_o

    ,output logic   app_new_flow_notif_val_o
    ,input  logic   app_new_flow_notif_rdy_i
);

    typedef enum logic [1:0] {
        IDLE,
        INSTALL,
        NOTIFY
    } new_flow_state_e;

    new_flow_state_e state_q;
    new_flow_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_comb begin
        state_nxt                = state_q;
        slow_path_rdy_o          = 1'b0;
        slow_path_done_o         = 1'b0;
        flowid_req_o             = 1'b0;
        store_flowid_o           = 1'b0;
        app_new_flow_notif_val_o = 1'b0;

        case (state_q)
            IDLE: begin
                slow_path_rdy_o = 1'b1;
                if (slow_path_val_i) begin
                    state_nxt = INSTALL;
                end
            end
            INSTALL: begin
                if (flowid_avail_i) begin
                    flowid_req_o   = 1'b1;
                    store_flowid_o = 1'b1;
                    state_nxt      = NOTIFY;
                end else begin
                    // SYN is consumed silently when the table is full
                    slow_path_done_o = 1'b1;
                    state_nxt        = IDLE;
                end
            end
            NOTIFY: begin
                app_new_flow_notif_val_o = 1'b1;
                if (app_new_flow_notif_rdy_i) begin
                    slow_path_done_o = 1'b1;
                    state_nxt        = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

endmodule

//--- tcp_rx_ctrl.sv
`timescale 1ns/1ps

module tcp_rx_ctrl (
     input  logic   clk
    ,input  logic   rst_n_i

    ,input  logic   recv_hdr_val_i
    ,output logic   recv_hdr_rdy_o

    ,input  logic   read_flow_cam_hit_i
    ,input  logic   saved_syn_i

    ,output logic   tcp_rx_dst_hdr_val_o
    ,input  logic   dst_tcp_rx_hdr_rdy_i

    ,output logic   slow_path_val_o
    ,input  logic   slow_path_rdy_i
    ,input  logic   slow_path_done_i

    ,output logic   ctrl_datap_save_input_o
    ,output logic   ctrl_datap_save_lookup_o
    ,output logic   ctrl_datap_save_state_o
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        UPDATE,
        OUTPUT,
        SLOW_REQ,
        SLOW_WAIT
    } rx_ctrl_state_e;

    rx_ctrl_state_e state_q;
    rx_ctrl_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_comb begin
        state_nxt                = state_q;
        recv_hdr_rdy_o           = 1'b0;
        tcp_rx_dst_hdr_val_o     = 1'b0;
        slow_path_val_o          = 1'b0;
        ctrl_datap_save_input_o  = 1'b0;
        ctrl_datap_save_lookup_o = 1'b0;
        ctrl_datap_save_state_o  = 1'b0;

        case (state_q)
            IDLE: begin
                recv_hdr_rdy_o          = 1'b1;
                ctrl_datap_save_input_o = recv_hdr_val_i;
                if (recv_hdr_val_i) begin
                    state_nxt = LOOKUP;
                end
            end
            // Fast path on a hit, slow path on a new SYN, anything else is dropped
            LOOKUP: begin
                if (read_flow_cam_hit_i && !saved_syn_i) begin
                    ctrl_datap_save_lookup_o = 1'b1;
                    state_nxt                = UPDATE;
                end else if (!read_flow_cam_hit_i && saved_syn_i) begin
                    slow_path_val_o = 1'b1;
                    state_nxt       = slow_path_rdy_i ? SLOW_WAIT : SLOW_REQ;
                end else begin
                    state_nxt = IDLE;
                end
            end
            UPDATE: begin
                ctrl_datap_save_state_o = 1'b1;
                state_nxt               = OUTPUT;
            end
            OUTPUT: begin
                tcp_rx_dst_hdr_val_o = 1'b1;
                if (dst_tcp_rx_hdr_rdy_i) begin
                    state_nxt = IDLE;
                end
            end
            SLOW_REQ: begin
                slow_path_val_o = 1'b1;
                if (slow_path_rdy_i) begin
                    state_nxt = SLOW_WAIT;
                end
            end
            SLOW_WAIT: begin
                if (slow_path_done_i) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Output header is held until the sink takes it
    a_dst_val_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        tcp_rx_dst_hdr_val_o && !dst_tcp_rx_hdr_rdy_i |=> tcp_rx_dst_hdr_val_o);

endmodule

//--- flow_cam.sv
`timescale 1ns/1ps

module flow_cam #(
    parameter int MAX_FLOW_CNT = 8
) (
     input  logic                       clk
    ,input  logic                       rst_n_i

    ,input  logic                       w_v_i
    ,input  tcp_rx_pkg::four_tuple_t    w_tag_i
    ,input  tcp_rx_pkg::flowid_t        w_data_i

    ,input  tcp_rx_pkg::four_tuple_t    r_tag_i
    ,output tcp_rx_pkg::flowid_t        r_data_o
    ,output logic                       r_v_o
);
    import tcp_rx_pkg::*;

    logic [MAX_FLOW_CNT-1:0]    valid_q;
    four_tuple_t                tag_q  [MAX_FLOW_CNT];
    flowid_t                    data_q [MAX_FLOW_CNT];
    flowid_t                    free_idx;
    logic                       free_avail;

    // Tags are unique, so at most one entry matches
    always_comb begin
        r_v_o    = 1'b0;
        r_data_o = '0;
        for (int i = 0; i < MAX_FLOW_CNT; i++) begin
            if (valid_q[i] && (tag_q[i] == r_tag_i)) begin
                r_v_o    = 1'b1;
                r_data_o = data_q[i];
            end
        end
    end

    always_comb begin
        free_idx = '0;
        for (int i = MAX_FLOW_CNT - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = flowid_t'(i);
            end
        end
    end

    assign free_avail = ~&valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (w_v_i && free_avail) begin
            valid_q[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_v_i && free_avail) begin
            tag_q[free_idx]  <= w_tag_i;
            data_q[free_idx] <= w_data_i;
        end
    end

    // Only tuples that missed in lookup get installed
    a_no_dup_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        w_v_i |-> !(r_v_o && (r_tag_i == w_tag_i)));

endmodule

//--- flowid_manager.sv
`timescale 1ns/1ps

module flowid_manager #(
    parameter int MAX_FLOW_CNT = 8
) (
     input  logic                   clk
    ,input  logic                   rst_n_i

    ,input  logic                   flowid_req_i
    ,output logic                   flowid_avail_o
    ,output tcp_rx_pkg::flowid_t    flowid_o
);
    import tcp_rx_pkg::*;

    logic [MAX_FLOW_CNT-1:0] used_q;

    // Scanning down lets the lowest free id win
    always_comb begin
        flowid_o = '0;
        for (int i = MAX_FLOW_CNT - 1; i >= 0; i--) begin
            if (!used_q[i]) begin
                flowid_o = flowid_t'(i);
            end
        end
    end

    assign flowid_avail_o = ~&used_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            used_q <= '0;
        end else if (flowid_req_i) begin
            used_q[flowid_o] <= 1'b1;
        end
    end

    a_req_only_when_avail: assert property (@(posedge clk) disable iff (!rst_n_i)
        flowid_req_i |-> flowid_avail_o);

endmodule

//--- tcp_rx_pkg.sv
package tcp_rx_pkg;

    // Field widths
    localparam int FLOWID_W      = 3;
    localparam int IP_ADDR_W     = 32;
    localparam int PORT_W        = 16;
    localparam int SEQ_NUM_W     = 32;
    localparam int PAYLOAD_LEN_W = 16;
    localparam int TCP_FLAGS_W   = 8;

    // Source IP, destination IP, source port, destination port
    localparam int FOUR_TUPLE_W  = 2 * IP_ADDR_W + 2 * PORT_W;

    typedef logic [IP_ADDR_W-1:0]     ip_addr_t;
    typedef logic [PORT_W-1:0]        port_t;

    // Wraps modulo 2^32
    typedef logic [SEQ_NUM_W-1:0]     seq_num_t;

    typedef logic [PAYLOAD_LEN_W-1:0] payload_len_t;
    typedef logic [TCP_FLAGS_W-1:0]   tcp_flags_t;
    typedef logic [FLOWID_W-1:0]      flowid_t;
    typedef logic [FOUR_TUPLE_W-1:0]  four_tuple_t;

    // Bit index of SYN within the flag byte
    localparam int TCP_FLAG_SYN = 1;

endpackage
